/* Makefile */
TOP := pokerTb
RTL := $(shell grep '^rtl/' filelist.f)

.PHONY: lint sim clean

# lint the design alone, the top level is the classifier
lint:
	verilator --lint-only -Wall --top-module pokerTop $(RTL)

# build and run, pass only when the testbench reports it
sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o simv
	@out="$$(./obj_dir/simv)"; echo "$$out"; \
		echo "$$out" | grep -qF "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* filelist.f */
rtl/pokerCardPkg.sv
rtl/pokerHandPkg.sv
rtl/rankMatcher.sv
rtl/straightDetector.sv
rtl/handFeatureStage.sv
rtl/handClassifier.sv
rtl/pokerTop.sv
verif/tbClock.sv
verif/pokerTb.sv

/* rtl/handClassifier.sv */
`timescale 1ns/1ns

module handClassifier
	import pokerHandPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic featValid,
	input handFeaturesT features,
	output logic typeValid,
	output handTypeT handType
);

	// encoded type of the current features ahead of the register
	handTypeT nextType;

	// priority encoder with the strongest hand first
	always_comb begin
		if (features.straight && features.flush) begin
			nextType = HAND_STRAIGHT_FLUSH;
		end else if (features.pairCount == PAIRS_FOUR_KIND) begin
			nextType = HAND_FOUR_KIND;
		end else if (features.pairCount == PAIRS_FULL_HOUSE) begin
			nextType = HAND_FULL_HOUSE;
		end else if (features.flush) begin
			// a suited quad or full house was caught above
			nextType = HAND_FLUSH;
		end else if (features.straight) begin
			nextType = HAND_STRAIGHT;
		end else if (features.pairCount == PAIRS_THREE_KIND) begin
			nextType = HAND_THREE_KIND;
		end else if (features.pairCount == PAIRS_TWO) begin
			nextType = HAND_TWO_PAIRS;
		end else if (features.pairCount == PAIRS_ONE) begin
			nextType = HAND_ONE_PAIR;
		end else begin
			nextType = HAND_HIGH_CARD;
		end
	end

	// result register that holds between valid hands
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			typeValid <= 1'b0;
			handType <= '0;
		end else begin
			typeValid <= featValid;
			if (featValid) begin
				handType <= nextType;
			end
		end
	end

	// a straight has five distinct ranks so the rank matcher finds no pair
	aStraightNoPairs: assert property (@(posedge clk) disable iff (!rstN)
		featValid |-> !(features.straight && features.pairCount != '0));

endmodule

/* rtl/handFeatureStage.sv */
`timescale 1ns/1ns

module handFeatureStage
	import pokerCardPkg::*;
	import pokerHandPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic handValid,
	input handT hand,
	output logic featValid,
	output handFeaturesT features
);

	// combinational features of the incoming hand
	logic flush;
	logic straight;
	pairCountT pairCount;

	// flush when every suit matches card 0
	always_comb begin
		flush = 1'b1;
		for (int i = 1; i < HAND_SIZE; i++) begin
			if (hand[i].suit != hand[0].suit) begin
				flush = 1'b0;
			end
		end
	end

	// rank multiplicity
	rankMatcher uRankMatcher (
		.hand(hand),
		.pairCount(pairCount)
	);

	// consecutive-rank check
	straightDetector uStraightDetector (
		.hand(hand),
		.straight(straight)
	);

	// feature register, loaded only for a valid hand
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			featValid <= 1'b0;
			features <= '0;
		end else begin
			// strobe follows handValid by exactly one cycle
			featValid <= handValid;
			if (handValid) begin
				features.flush <= flush;
				features.straight <= straight;
				features.pairCount <= pairCount;
			end
		end
	end

	// each card of a valid hand must carry a rank from ace to king
	for (genvar c = 0; c < HAND_SIZE; c++) begin : gRankCheck
		aRankLegal: assert property (@(posedge clk) disable iff (!rstN)
			handValid |-> (hand[c].rank >= RANK_ACE && hand[c].rank <= RANK_KING));
	end

endmodule

/* rtl/pokerCardPkg.sv */
package pokerCardPkg;

	// cards dealt per hand
	localparam int HAND_SIZE = 5;

	// card rank, ace is 1 and king is 13
	typedef logic [3:0] rankT;

	// card suit, four suits in two bits
	typedef logic [1:0] suitT;

	// one card, suit on the upper bits and rank on the lower bits
	// same 6-bit layout as the input bus of the gate-level checker
	typedef struct packed {
		suitT suit;
		rankT rank;
	} cardT;

	// five cards side by side, card 0 in the low bits
	typedef cardT [HAND_SIZE-1:0] handT;

	// ends of the legal rank range
	localparam rankT RANK_ACE = 4'd1;
	localparam rankT RANK_KING = 4'd13;

endpackage

/* rtl/pokerHandPkg.sv */
package pokerHandPkg;

	// number of card pairs sharing a rank, 0 up to 6
	typedef logic [2:0] pairCountT;

	// encoded hand type, 0 is the weakest
	typedef logic [3:0] handTypeT;

	// hand-type codes in ranking order
	localparam handTypeT HAND_HIGH_CARD = 4'd0;
	localparam handTypeT HAND_ONE_PAIR = 4'd1;
	localparam handTypeT HAND_TWO_PAIRS = 4'd2;
	localparam handTypeT HAND_THREE_KIND = 4'd3;
	localparam handTypeT HAND_STRAIGHT = 4'd4;
	localparam handTypeT HAND_FLUSH = 4'd5;
	localparam handTypeT HAND_FULL_HOUSE = 4'd6;
	localparam handTypeT HAND_FOUR_KIND = 4'd7;
	localparam handTypeT HAND_STRAIGHT_FLUSH = 4'd8;

	// equal-rank pair counts of each rank shape
	// a triple gives 3 pairs, triple plus pair gives 4, a quad gives 6
	localparam pairCountT PAIRS_ONE = 3'd1;
	localparam pairCountT PAIRS_TWO = 3'd2;
	localparam pairCountT PAIRS_THREE_KIND = 3'd3;
	localparam pairCountT PAIRS_FULL_HOUSE = 3'd4;
	localparam pairCountT PAIRS_FOUR_KIND = 3'd6;

	// per-hand features carried from the feature stage to the classifier
	typedef struct packed {
		logic flush;
		logic straight;
		pairCountT pairCount;
	} handFeaturesT;

endpackage

/* rtl/pokerTop.sv */
`timescale 1ns/1ns

module pokerTop
	import pokerCardPkg::*;
	import pokerHandPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic handValid,
	input handT hand,
	output logic typeValid,
	output handTypeT handType
);

	// features of the hand one cycle after it arrives
	logic featValid;
	handFeaturesT features;

	// stage 1, flush, straight and pair count
	handFeatureStage uFeatureStage (
		.clk(clk),
		.rstN(rstN),
		.handValid(handValid),
		.hand(hand),
		.featValid(featValid),
		.features(features)
	);

	// stage 2, priority encode into the hand type
	handClassifier uClassifier (
		.clk(clk),
		.rstN(rstN),
		.featValid(featValid),
		.features(features),
		.typeValid(typeValid),
		.handType(handType)
	);

endmodule

/* rtl/rankMatcher.sv */
`timescale 1ns/1ns

module rankMatcher
	import pokerCardPkg::*;
	import pokerHandPkg::*;
(
	input handT hand,
	output pairCountT pairCount
);

	// number of distinct card pairs in a hand, 5 choose 2
	localparam int NUM_PAIRS = HAND_SIZE * (HAND_SIZE - 1) / 2;

	// one flag per card pair, set when both ranks are equal
	logic [NUM_PAIRS-1:0] pairMatch;

	// walk every unordered pair (i, j) with i < j
	// flags are packed in order 01 02 03 04 12 13 14 23 24 34
	always_comb begin
		int idx;
		idx = 0;
		pairMatch = '0;
		for (int i = 0; i < HAND_SIZE - 1; i++) begin
			for (int j = i + 1; j < HAND_SIZE; j++) begin
				// suits are ignored here, only rank matters
				pairMatch[idx] = (hand[i].rank == hand[j].rank);
				idx = idx + 1;
			end
		end
	end

	// add up the match flags
	// the sum alone tells the rank shape:
	// 0 all distinct
	// 1 one pair
	// 2 two pairs
	// 3 three of a kind
	// 4 full house
	// 6 four of a kind
	// 5 cannot happen with five cards
	always_comb begin
		pairCountT sum;
		sum = '0;
		for (int k = 0; k < NUM_PAIRS; k++) begin
			sum = sum + pairCountT'(pairMatch[k]);
		end
		pairCount = sum;
	end

endmodule

/* rtl/straightDetector.sv */
`timescale 1ns/1ns

module straightDetector
	import pokerCardPkg::*;
(
	input handT hand,
	output logic straight
);

	// number of five-rank windows, starts 1..9 plus the ace-high one
	localparam int NUM_WINDOWS = 10;

	// one bit per legal rank, set when some card holds that rank
	logic [RANK_KING:RANK_ACE] rankPresent;

	// one bit per window, set when all its ranks are present
	logic [NUM_WINDOWS-1:0] windowHit;

	// rank set of the hand
	// out-of-range ranks are dropped, the assertion upstream flags them
	always_comb begin
		rankPresent = '0;
		for (int i = 0; i < HAND_SIZE; i++) begin
			if (hand[i].rank >= RANK_ACE && hand[i].rank <= RANK_KING) begin
				rankPresent[hand[i].rank] = 1'b1;
			end
		end
	end

	// test each run of five consecutive ranks
	always_comb begin
		// low windows, ace counts as 1 so 1-5 is the first one
		for (int s = 0; s < NUM_WINDOWS - 1; s++) begin
			windowHit[s] = &rankPresent[RANK_ACE + s +: 5];
		end
		// ace high, 10 J Q K plus the ace
		// no window wraps past the king, so K A 2 3 4 is not a straight
		windowHit[NUM_WINDOWS-1] = (&rankPresent[RANK_KING -: 4]) & rankPresent[RANK_ACE];
	end

	// five cards fill a window only if all five ranks differ,
	// so a hit already implies no pairs
	assign straight = |windowHit;

endmodule

/* verif/pokerTb.sv */
`timescale 1ns/1ns

module pokerTb
	import pokerCardPkg::*;
	import pokerHandPkg::*;
();

	// wait limits in clock cycles
	localparam int RESET_LIMIT = 40;
	localparam int DRAIN_LIMIT = 8;
	localparam int RANDOM_HANDS = 500;

	logic clk;
	logic rstN;
	logic handValid;
	handT hand;
	logic typeValid;
	handTypeT handType;

	// expected codes, oldest hand first
	handTypeT expQ[$];
	// handValid as seen two rising edges ago
	logic [1:0] validPipe;
	logic [31:0] lcgState;
	int errCount;
	int errAtStart;
	int testNum;
	int passCount;
	int failCount;

	// 20 ns clock, reset over 16 cycles
	tbClock #(.HALF_PERIOD(10), .RESET_CYCLES(16)) uClock (.clk(clk), .rstN(rstN));

	pokerTop i_dut (
		.clk(clk),
		.rstN(rstN),
		.handValid(handValid),
		.hand(hand),
		.typeValid(typeValid),
		.handType(handType)
	);

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic handT makeHand(input rankT r0, input rankT r1, input rankT r2,
			input rankT r3, input rankT r4, input logic sameSuit);
		handT h;
		rankT ranks [HAND_SIZE];
		ranks = '{r0, r1, r2, r3, r4};
		for (int i = 0; i < HAND_SIZE; i++) begin
			h[i].rank = ranks[i];
			// unsuited hands cycle the suits so they never all match
			h[i].suit = sameSuit ? 2'd2 : suitT'(i % 4);
		end
		return h;
	endfunction

	function automatic handT randomHand();
		handT h;
		logic [31:0] r;
		logic suited;
		suitT common;
		r = nextRand();
		// roughly one hand in eight is suited so flushes show up
		suited = (r[31:29] == 3'd0);
		common = r[28:27];
		// five cards of one rank cannot come from a single deck
		do begin
			for (int i = 0; i < HAND_SIZE; i++) begin
				r = nextRand();
				h[i].rank = rankT'(r[31:16] % 16'd13 + 16'd1);
				h[i].suit = suited ? common : r[25:24];
			end
		end while (h[0].rank == h[1].rank && h[0].rank == h[2].rank
			&& h[0].rank == h[3].rank && h[0].rank == h[4].rank);
		return h;
	endfunction

	// reference model, built on rank multiplicities and the rank span
	function automatic handTypeT modelType(input handT h);
		int cnt [16] = '{default: 0};
		int quads = 0;
		int trips = 0;
		int pairs = 0;
		int distinct = 0;
		int lo = 15;
		int hi = 0;
		int rk;
		logic flush = 1'b1;
		logic straight;
		for (int i = 0; i < HAND_SIZE; i++) begin
			rk = int'(h[i].rank);
			cnt[rk]++;
			lo = (rk < lo) ? rk : lo;
			hi = (rk > hi) ? rk : hi;
			if (h[i].suit != h[0].suit) begin
				flush = 1'b0;
			end
		end
		for (int r = 1; r <= 13; r++) begin
			quads += (cnt[r] == 4) ? 1 : 0;
			trips += (cnt[r] == 3) ? 1 : 0;
			pairs += (cnt[r] == 2) ? 1 : 0;
			distinct += (cnt[r] != 0) ? 1 : 0;
		end
		// five distinct ranks in a span of five, or 10 J Q K with the ace
		straight = (distinct == 5) && ((hi - lo == 4) || (cnt[1] != 0 && cnt[10] != 0
			&& cnt[11] != 0 && cnt[12] != 0 && cnt[13] != 0));
		if (straight && flush) return HAND_STRAIGHT_FLUSH;
		if (quads != 0) return HAND_FOUR_KIND;
		if (trips != 0 && pairs != 0) return HAND_FULL_HOUSE;
		if (flush) return HAND_FLUSH;
		if (straight) return HAND_STRAIGHT;
		if (trips != 0) return HAND_THREE_KIND;
		if (pairs == 2) return HAND_TWO_PAIRS;
		if (pairs == 1) return HAND_ONE_PAIR;
		return HAND_HIGH_CARD;
	endfunction

	task automatic checkHandType(input handTypeT got, input handTypeT expected);
		if (got !== expected) begin
			$display("FAIL %0t: handType is %0d, expected %0d", $time, got, expected);
			errCount++;
		end
	endtask

	task automatic checkValid(input logic got, input logic expected);
		if (got !== expected) begin
			$display("FAIL %0t: typeValid is %b, expected %b", $time, got, expected);
			errCount++;
		end
	endtask

	task automatic abortOnTimeout(input string what);
		$display("timeout at %0t while waiting for %s", $time, what);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	// one hand per falling edge, handValid stays high until an idle cycle
	task automatic sendHand(input handT h, input handTypeT expected);
		@(negedge clk);
		handValid = 1'b1;
		hand = h;
		expQ.push_back(expected);
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(negedge clk);
			handValid = 1'b0;
		end
	endtask

	task automatic waitReset();
		int cycles = 0;
		while (rstN !== 1'b1 && cycles < RESET_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (rstN !== 1'b1) begin
			abortOnTimeout("reset release");
		end
	endtask

	// stop driving, then wait until every outstanding result came back
	task automatic drainResults(input string what);
		int cycles = 0;
		idleCycles(1);
		do begin
			@(posedge clk);
			cycles++;
		end while (expQ.size() != 0 && cycles < DRAIN_LIMIT);
		if (expQ.size() != 0) begin
			abortOnTimeout($sformatf("%0d results of %s", expQ.size(), what));
		end
	endtask

	task automatic endTest(input string name);
		testNum++;
		if (errCount == errAtStart) begin
			passCount++;
			$display("test %0d %s: ok", testNum, name);
		end else begin
			failCount++;
			$display("test %0d %s: %0d errors", testNum, name, errCount - errAtStart);
		end
		errAtStart = errCount;
	endtask

	task automatic runRandomHands(input int count);
		handT h;
		int gap;
		for (int n = 0; n < count; n++) begin
			h = randomHand();
			sendHand(h, modelType(h));
			// half the hands follow back to back, the rest after 1 or 2 idle cycles
			gap = int'(nextRand() >> 30);
			if (gap > 1) begin
				idleCycles(gap - 1);
			end
		end
	endtask

	// expected strobe timing, sampled where handValid is stable
	always @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validPipe <= '0;
		end else begin
			validPipe <= {validPipe[0], handValid};
		end
	end

	// outputs change on the rising edge, check them on the falling one
	always @(negedge clk) begin
		checkValid(typeValid, validPipe[1]);
		if (typeValid === 1'b1) begin
			if (expQ.size() == 0) begin
				$display("typeValid pulsed at %0t with no hand outstanding", $time);
				errCount++;
			end else begin
				checkHandType(handType, expQ.pop_front());
			end
		end
	end

	initial begin
		handValid = 1'b0;
		hand = '0;
		lcgState = 32'h99be4aef;
		errCount = 0;
		errAtStart = 0;
		testNum = 0;
		passCount = 0;
		failCount = 0;

		waitReset();
		idleCycles(4);
		drainResults("the idle period");
		endTest("reset keeps typeValid low");

		sendHand(makeHand(4'd2, 4'd5, 4'd7, 4'd9, 4'd12, 1'b0), HAND_HIGH_CARD);
		sendHand(makeHand(4'd3, 4'd3, 4'd8, 4'd10, 4'd13, 1'b0), HAND_ONE_PAIR);
		sendHand(makeHand(4'd4, 4'd4, 4'd9, 4'd9, 4'd1, 1'b0), HAND_TWO_PAIRS);
		sendHand(makeHand(4'd7, 4'd7, 4'd7, 4'd2, 4'd11, 1'b0), HAND_THREE_KIND);
		sendHand(makeHand(4'd5, 4'd6, 4'd7, 4'd8, 4'd9, 1'b0), HAND_STRAIGHT);
		sendHand(makeHand(4'd2, 4'd5, 4'd7, 4'd9, 4'd12, 1'b1), HAND_FLUSH);
		sendHand(makeHand(4'd6, 4'd6, 4'd6, 4'd13, 4'd13, 1'b0), HAND_FULL_HOUSE);
		sendHand(makeHand(4'd1, 4'd1, 4'd1, 4'd1, 4'd8, 1'b0), HAND_FOUR_KIND);
		sendHand(makeHand(4'd9, 4'd10, 4'd11, 4'd12, 4'd13, 1'b1), HAND_STRAIGHT_FLUSH);
		// ace low, ace high, and the king-ace wrap that is no straight
		sendHand(makeHand(4'd3, 4'd1, 4'd4, 4'd5, 4'd2, 1'b0), HAND_STRAIGHT);
		sendHand(makeHand(4'd10, 4'd13, 4'd1, 4'd12, 4'd11, 1'b0), HAND_STRAIGHT);
		sendHand(makeHand(4'd11, 4'd12, 4'd13, 4'd1, 4'd2, 1'b0), HAND_HIGH_CARD);
		drainResults("the directed hands");
		endTest("directed hand types");

		sendHand(makeHand(4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 1'b1), HAND_STRAIGHT_FLUSH);
		sendHand(makeHand(4'd12, 4'd1, 4'd10, 4'd13, 4'd11, 1'b1), HAND_STRAIGHT_FLUSH);
		sendHand(makeHand(4'd1, 4'd3, 4'd6, 4'd9, 4'd13, 1'b1), HAND_FLUSH);
		drainResults("the suited hands");
		endTest("suited hands");

		// rank shape outranks the flush
		sendHand(makeHand(4'd8, 4'd8, 4'd8, 4'd4, 4'd4, 1'b1), HAND_FULL_HOUSE);
		sendHand(makeHand(4'd12, 4'd12, 4'd12, 4'd12, 4'd3, 1'b1), HAND_FOUR_KIND);
		sendHand(makeHand(4'd13, 4'd2, 4'd13, 4'd2, 4'd13, 1'b0), HAND_FULL_HOUSE);
		sendHand(makeHand(4'd5, 4'd9, 4'd5, 4'd5, 4'd5, 1'b0), HAND_FOUR_KIND);
		drainResults("the full house and quad hands");
		endTest("full house and four of a kind");

		// the gap cycle must give no pulse, the monitor checks every cycle
		sendHand(makeHand(4'd6, 4'd7, 4'd8, 4'd9, 4'd10, 1'b0), HAND_STRAIGHT);
		sendHand(makeHand(4'd2, 4'd9, 4'd9, 4'd4, 4'd13, 1'b0), HAND_ONE_PAIR);
		sendHand(makeHand(4'd2, 4'd4, 4'd6, 4'd8, 4'd13, 1'b1), HAND_FLUSH);
		sendHand(makeHand(4'd3, 4'd11, 4'd3, 4'd3, 4'd6, 1'b0), HAND_THREE_KIND);
		idleCycles(1);
		sendHand(makeHand(4'd10, 4'd2, 4'd10, 4'd2, 4'd7, 1'b0), HAND_TWO_PAIRS);
		sendHand(makeHand(4'd1, 4'd4, 4'd7, 4'd10, 4'd13, 1'b0), HAND_HIGH_CARD);
		drainResults("the back-to-back hands");
		endTest("back-to-back hands");

		runRandomHands(RANDOM_HANDS);
		drainResults("the random hands");
		endTest("random hands against the model");

		$display("tests passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* verif/tbClock.sv */
`timescale 1ns/1ns

module tbClock #(
	parameter int HALF_PERIOD = 10,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rstN
);

	// free-running clock, starts low
	initial begin
		clk = 1'b0;
		forever begin
			#(HALF_PERIOD) clk = ~clk;
		end
	end

	// hold reset over the first rising edges, release on a falling edge
	initial begin
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule
